/* hw/opq_consts.svh */
// Width and depth constants of the operand queue, included by the package and the RTL modules
`ifndef OPQ_CONSTS_SVH
`define OPQ_CONSTS_SVH

// Operand word width in bits
`define OPQ_ELEN 64

// Command FIFO depth, one entry per vector operation
`define OPQ_CMD_DEPTH 2

// Data FIFO depth, which is also the number of read credits
`define OPQ_DATA_DEPTH 2

// Element count width, covers up to 1023 elements
`define OPQ_CNT_W 10

// Number of consumer ready bits
`define OPQ_NR_FU 2

`endif

/* hw/opq_pkg.sv */
// Types shared by the operand queue RTL and its testbench; import where the types are needed
`default_nettype none

`include "opq_consts.svh"

package opq_pkg;

  // Operand word from the register file
  typedef logic [`OPQ_ELEN-1:0] elen_t;

  // Number of elements in one vector operation
  typedef logic [`OPQ_CNT_W-1:0] elem_cnt_t;

  // Byte offset of the next source element inside the head word
  typedef logic [$clog2(`OPQ_ELEN/8)-1:0] byte_sel_t;

  // Source element width
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } eew_e;

  // Conversion applied on the way out
  typedef enum logic [2:0] {
    CONV_NONE  = 3'd0,
    CONV_SEXT2 = 3'd1,
    CONV_SEXT4 = 3'd2,
    CONV_SEXT8 = 3'd3,
    CONV_ZEXT2 = 3'd4,
    CONV_ZEXT4 = 3'd5,
    CONV_ZEXT8 = 3'd6
  } conv_e;

  typedef enum logic {
    FU_ALU_SLDU     = 1'b0,
    FU_MFPU_ADDRGEN = 1'b1
  } target_fu_e;

  // Log2 of the widening factor, zero when the word leaves unchanged
  function automatic logic [1:0] widen_log(conv_e conv, eew_e eew);
    logic [1:0] f;
    case (conv)
      CONV_SEXT2, CONV_ZEXT2: f = 2'd1;
      CONV_SEXT4, CONV_ZEXT4: f = 2'd2;
      CONV_SEXT8, CONV_ZEXT8: f = 2'd3;
      default:                f = 2'd0;
    endcase
    // Widened element has to fit in one word
    if ({1'b0, eew} + {1'b0, f} > 3'd3) f = 2'd0;
    return f;
  endfunction

endpackage

`default_nettype wire

/* hw/opq_fifo.sv */
// Register FIFO with synchronous flush, instantiated for the command and the data buffers
`timescale 1ns/1ps
`default_nettype none

module opq_fifo #(
  parameter int unsigned Depth = 2,
  parameter int unsigned Width = 64
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             flush_i,
  input  logic             push_i,
  input  logic             pop_i,
  input  logic [Width-1:0] data_i,
  output logic [Width-1:0] data_o,
  output logic             empty_o,
  output logic             full_o
);

  localparam int unsigned PtrW   = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned UsageW = $clog2(Depth + 1);
  localparam logic [PtrW-1:0] LastIdx = PtrW'(Depth - 1);

  logic [Width-1:0]  mem_q [Depth];
  logic [PtrW-1:0]   rd_ptr_q;
  logic [PtrW-1:0]   wr_ptr_q;
  logic [UsageW-1:0] usage_q;
  logic              do_push;
  logic              do_pop;

  assign empty_o = (usage_q == '0);
  assign full_o  = (usage_q == UsageW'(Depth));

  // Head entry is always visible
  assign data_o = mem_q[rd_ptr_q];

  assign do_pop  = pop_i && !empty_o;
  // A full buffer still takes a word when the head leaves in the same cycle
  assign do_push = push_i && (!full_o || do_pop);

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      usage_q  <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == LastIdx) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == LastIdx) ? '0 : rd_ptr_q + 1'b1;
      end
      usage_q <= usage_q + UsageW'(do_push) - UsageW'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin : p_mem
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

/* hw/opq_credit_counter.sv */
// Credit counter for words issued to the queue; its ready level gates new register file reads
`timescale 1ns/1ps
`default_nettype none

`include "opq_consts.svh"

module opq_credit_counter (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic flush_i,
  input  logic issued_i,
  input  logic consumed_i,
  output logic ready_o
);

  localparam int unsigned CntW = $clog2(`OPQ_DATA_DEPTH + 1);
  localparam logic [CntW-1:0] Credits = CntW'(`OPQ_DATA_DEPTH);

  // Words promised to the data FIFO and not popped yet
  logic [CntW-1:0] count_d;
  logic [CntW-1:0] count_q;
  logic            ready_d;
  logic            ready_q;

  always_comb begin : p_count
    count_d = count_q + CntW'(issued_i) - CntW'(consumed_i);
    if (flush_i) begin
      count_d = '0;
    end
    ready_d = (count_d < Credits);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_count_ff
    if (!rst_ni) begin
      count_q <= '0;
      ready_q <= 1'b1;
    end else begin
      count_q <= count_d;
      ready_q <= ready_d;
    end
  end

  assign ready_o = ready_q;

endmodule

`default_nettype wire

/* hw/opq_widen.sv */
// Combinational integer sign or zero extension of the head word, feeding the queue output
`timescale 1ns/1ps
`default_nettype none

module opq_widen (
  input  opq_pkg::elen_t     word_i,
  input  opq_pkg::conv_e     conv_i,
  input  opq_pkg::eew_e      eew_i,
  input  opq_pkg::byte_sel_t sel_i,
  output opq_pkg::elen_t     word_o
);

  import opq_pkg::*;

  localparam int unsigned Elen = $bits(elen_t);

  logic [1:0] factor_log;
  logic       sign_ext;
  // Log2 of the source and output element widths in bits
  logic [3:0] src_w_log;
  logic [3:0] dst_w_log;

  // Zero for pass-through and for widenings that would not fit
  assign factor_log = widen_log(conv_i, eew_i);
  assign sign_ext   = conv_i inside {CONV_SEXT2, CONV_SEXT4, CONV_SEXT8};

  assign src_w_log = 4'd3 + 4'(eew_i);
  assign dst_w_log = src_w_log + 4'(factor_log);

  //////////////////////////////////////////////////
  // Bit mapping
  //////////////////////////////////////////////////

  // Output bit b belongs to output element b/dst_w at offset b%dst_w.
  // Source element e starts e*src_w bits past the byte select
  always_comb begin : p_extend
    logic [6:0] pos;
    logic [6:0] inner;
    logic [6:0] base;
    logic [6:0] src_w;
    logic [5:0] src_bit;
    logic       is_ext;

    word_o = word_i;
    src_w  = 7'd1 << src_w_log;
    pos    = '0;
    inner  = '0;
    base   = '0;
    src_bit = '0;
    is_ext = 1'b0;

    if (factor_log != 2'd0) begin
      for (int b = 0; b < Elen; b++) begin
        pos   = 7'(b);
        base  = {1'b0, sel_i, 3'b000} + ((pos >> dst_w_log) << src_w_log);
        inner = pos & ((7'd1 << dst_w_log) - 7'd1);

        // Upper part of an output element repeats the source MSB or is zero
        is_ext = (inner >= src_w);
        if (is_ext) begin
          src_bit = 6'(base + src_w - 7'd1);
        end else begin
          src_bit = 6'(base + inner);
        end

        word_o[b] = is_ext ? (sign_ext & word_i[src_bit]) : word_i[src_bit];
      end
    end
  end

endmodule

`default_nettype wire

/* hw/opq_sequencer.sv */
// Output sequencer of the operand queue; counts beats and elements and decides the FIFO pops
`timescale 1ns/1ps
`default_nettype none

`include "opq_consts.svh"

module opq_sequencer (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  input  logic                  data_empty_i,
  input  opq_pkg::conv_e        cmd_conv_i,
  input  opq_pkg::eew_e         cmd_eew_i,
  input  opq_pkg::elem_cnt_t    cmd_elem_count_i,
  input  logic [`OPQ_NR_FU-1:0] fu_ready_i,
  output opq_pkg::byte_sel_t    sel_o,
  output logic                  valid_o,
  output logic                  data_pop_o,
  output logic                  cmd_pop_o
);

  import opq_pkg::*;

  localparam int unsigned CntSumW = `OPQ_CNT_W + 1;

  byte_sel_t          sel_d;
  byte_sel_t          sel_q;
  elem_cnt_t          cnt_d;
  elem_cnt_t          cnt_q;
  logic               beat;
  logic [1:0]         factor_log;
  logic [1:0]         elem_shift;
  logic [3:0]         sel_sum;
  logic [CntSumW-1:0] cnt_sum;

  assign valid_o = !data_empty_i;
  assign beat    = valid_o && |fu_ready_i;

  assign factor_log = widen_log(cmd_conv_i, cmd_eew_i);

  // Elements per beat are 2^(3 - eew - factor)
  assign elem_shift = 2'd3 - 2'(cmd_eew_i) - factor_log;
  assign cnt_sum    = {1'b0, cnt_q} + (CntSumW'(1) << elem_shift);

  // Select steps by 8/F bytes; the carry out marks a used-up word
  assign sel_sum = {1'b0, sel_q} + (4'd8 >> factor_log);

  always_comb begin : p_next
    sel_d      = sel_q;
    cnt_d      = cnt_q;
    data_pop_o = 1'b0;
    cmd_pop_o  = 1'b0;

    if (beat) begin
      sel_d      = sel_sum[2:0];
      cnt_d      = cnt_sum[`OPQ_CNT_W-1:0];
      data_pop_o = sel_sum[3];
      // Last beat of the command releases the word as well
      if (cnt_sum >= {1'b0, cmd_elem_count_i}) begin
        data_pop_o = 1'b1;
        cmd_pop_o  = 1'b1;
        sel_d      = '0;
        cnt_d      = '0;
      end
    end

    if (flush_i) begin
      sel_d = '0;
      cnt_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state_ff
    if (!rst_ni) begin
      sel_q <= '0;
      cnt_q <= '0;
    end else begin
      sel_q <= sel_d;
      cnt_q <= cnt_d;
    end
  end

  assign sel_o = sel_q;

endmodule

`default_nettype wire

/* hw/operand_queue.sv */
// Top level of the lane operand queue, between the register file and the functional units
`timescale 1ns/1ps
`default_nettype none

`include "opq_consts.svh"

module operand_queue (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  input  logic                  cmd_valid_i,
  input  opq_pkg::conv_e        cmd_conv_i,
  input  opq_pkg::eew_e         cmd_eew_i,
  input  opq_pkg::elem_cnt_t    cmd_elem_count_i,
  input  opq_pkg::target_fu_e   cmd_target_fu_i,
  input  opq_pkg::elen_t        operand_i,
  input  logic                  operand_valid_i,
  input  logic                  operand_issued_i,
  input  logic [`OPQ_NR_FU-1:0] operand_ready_i,
  output logic                  operand_queue_ready_o,
  output opq_pkg::elen_t        operand_o,
  output opq_pkg::target_fu_e   operand_target_fu_o,
  output logic                  operand_valid_o
);

  import opq_pkg::*;

  localparam int unsigned TfuW  = $bits(target_fu_e);
  localparam int unsigned CntW  = $bits(elem_cnt_t);
  localparam int unsigned EewW  = $bits(eew_e);
  localparam int unsigned ConvW = $bits(conv_e);
  localparam int unsigned CmdW  = ConvW + EewW + CntW + TfuW;

  logic [CmdW-1:0] cmd_wdata;
  logic [CmdW-1:0] cmd_head;
  logic            cmd_pop;
  conv_e           head_conv;
  eew_e            head_eew;
  elem_cnt_t       head_count;
  target_fu_e      head_fu;
  elen_t           data_head;
  logic            data_empty;
  logic            data_pop;
  byte_sel_t       sel;

  //////////////////////////////////////////////////
  // Command buffer
  //////////////////////////////////////////////////

  // Packed as conv, eew, count, target from MSB down
  assign cmd_wdata = {cmd_conv_i, cmd_eew_i, cmd_elem_count_i, cmd_target_fu_i};

  opq_fifo #(
    .Depth(`OPQ_CMD_DEPTH),
    .Width(CmdW)
  ) i_cmd_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .flush_i(flush_i),
    .push_i (cmd_valid_i),
    .pop_i  (cmd_pop),
    .data_i (cmd_wdata),
    .data_o (cmd_head),
    .empty_o(),
    .full_o ()
  );

  assign head_fu    = target_fu_e'(cmd_head[0 +: TfuW]);
  assign head_count = cmd_head[TfuW +: CntW];
  assign head_eew   = eew_e'(cmd_head[TfuW + CntW +: EewW]);
  assign head_conv  = conv_e'(cmd_head[TfuW + CntW + EewW +: ConvW]);

  //////////////////////////////////////////////////
  // Data buffer and credits
  //////////////////////////////////////////////////

  opq_fifo #(
    .Depth(`OPQ_DATA_DEPTH),
    .Width($bits(elen_t))
  ) i_data_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .flush_i(flush_i),
    .push_i (operand_valid_i),
    .pop_i  (data_pop),
    .data_i (operand_i),
    .data_o (data_head),
    .empty_o(data_empty),
    .full_o ()
  );

  opq_credit_counter i_credit_counter (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .flush_i   (flush_i),
    .issued_i  (operand_issued_i),
    .consumed_i(data_pop),
    .ready_o   (operand_queue_ready_o)
  );

  //////////////////////////////////////////////////
  // Conversion and output
  //////////////////////////////////////////////////

  opq_widen i_widen (
    .word_i(data_head),
    .conv_i(head_conv),
    .eew_i (head_eew),
    .sel_i (sel),
    .word_o(operand_o)
  );

  opq_sequencer i_sequencer (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .data_empty_i    (data_empty),
    .cmd_conv_i      (head_conv),
    .cmd_eew_i       (head_eew),
    .cmd_elem_count_i(head_count),
    .fu_ready_i      (operand_ready_i),
    .sel_o           (sel),
    .valid_o         (operand_valid_o),
    .data_pop_o      (data_pop),
    .cmd_pop_o       (cmd_pop)
  );

  assign operand_target_fu_o = head_fu;

endmodule

`default_nettype wire

/* testbench/tb_operand_queue_tasks.svh */
// Directed test tasks of the operand queue testbench, included inside the testbench module

task automatic push_command(input conv_e conv, input eew_e eew, input elem_cnt_t count,
                            input target_fu_e fu);
  @(negedge clk_i);
  cmd_valid_i      = 1'b1;
  cmd_conv_i       = conv;
  cmd_eew_i        = eew;
  cmd_elem_count_i = count;
  cmd_target_fu_i  = fu;
  @(negedge clk_i);
  cmd_valid_i = 1'b0;
endtask

// Pushes a command, feeds nwords words under the credit rule and checks every beat.
// Ready drops for a few cycles at beat stall_beat, and for good at beat stop_beat if nonzero
task automatic run_command(input conv_e conv, input eew_e eew, input elem_cnt_t count,
                           input target_fu_e fu, input int nwords, input int stall_beat,
                           input int stop_beat);
  elen_t                 words[$];
  elen_t                 exp_q[$];
  elen_t                 w;
  elen_t                 held;
  int                    f;
  int                    sel;
  int                    sent;
  int                    idx;
  int                    issued;
  int                    beats;
  int                    stall_left;
  logic                  pending;
  logic [`OPQ_NR_FU-1:0] rdy;
  f = widen_factor(conv, eew);
  for (int i = 0; i < nwords; i++) begin
    next_word(w);
    words.push_back(w);
  end
  sel  = 0;
  sent = 0;
  idx  = 0;
  while (sent < count && idx < nwords) begin
    exp_q.push_back(expected_beat(words[idx], conv, eew, sel));
    sent += 64 / (f * (8 << eew));
    sel  += 8 / f;
    if (sel == 8) begin
      sel = 0;
      idx++;
    end
  end
  push_command(conv, eew, count, fu);
  beats      = 0;
  issued     = 0;
  pending    = 1'b0;
  stall_left = 6;
  held       = '0;
  while (exp_q.size() > 0 &&
         !(stop_beat > 0 && beats >= stop_beat && issued == nwords && !pending)) begin
    @(negedge clk_i);
    // Alternate the ready bit so that each one is exercised
    rdy = (beats % 2 == 0) ? 2'b01 : 2'b10;
    if (beats == stall_beat && stall_left > 0 && operand_valid_o) begin
      if (stall_left < 6 && operand_o !== held) begin
        report_error($sformatf("operand_o %h changed under back-pressure", operand_o));
      end
      held = operand_o;
      stall_left--;
      rdy = '0;
    end
    if (stop_beat > 0 && beats >= stop_beat) rdy = '0;
    if (operand_valid_o && rdy != '0) begin
      if (operand_o !== exp_q[0]) begin
        report_error($sformatf("beat %0d operand_o %h, expected %h", beats, operand_o,
                               exp_q[0]));
      end
      if (operand_target_fu_o !== fu) begin
        report_error($sformatf("beat %0d target unit %0d, expected %0d", beats,
                               operand_target_fu_o, fu));
      end
      void'(exp_q.pop_front());
      beats++;
      beats_checked++;
    end
    operand_ready_i = rdy;
    // A word arrives one cycle after its issue
    operand_valid_i = pending;
    operand_i       = pending ? words[issued-1] : '0;
    pending         = 1'b0;
    operand_issued_i = 1'b0;
    if (issued < nwords && operand_queue_ready_o) begin
      operand_issued_i = 1'b1;
      issued++;
      pending = 1'b1;
    end
  end
  @(negedge clk_i);
  operand_ready_i  = '0;
  operand_valid_i  = 1'b0;
  operand_issued_i = 1'b0;
  if (stop_beat == 0 && operand_valid_o !== 1'b0) begin
    report_error("operand_valid_o still high after the command ended");
  end
endtask

task automatic reset_values();
  @(negedge clk_i);
  if (operand_valid_o !== 1'b0) report_error("operand_valid_o high after reset");
  if (operand_queue_ready_o !== 1'b1) report_error("operand_queue_ready_o low after reset");
endtask

task automatic pass_through();
  run_command(CONV_NONE, EW16, 10'd12, FU_MFPU_ADDRGEN, 3, -1, 0);
  repeat (5) begin
    @(negedge clk_i);
    if (operand_valid_o !== 1'b0) report_error("operand_valid_o high on an idle queue");
  end
endtask

task automatic sign_zero_extension();
  int    f;
  conv_e conv;
  for (int c = 1; c <= 6; c++) begin
    for (int e = 0; e <= 2; e++) begin
      conv = conv_e'(c);
      f    = widen_factor(conv, eew_e'(e));
      if (f > 1) begin
        run_command(conv, eew_e'(e), elem_cnt_t'(8 >> e), FU_ALU_SLDU, 1, -1, 0);
      end
    end
  end
endtask

task automatic credit_flow();
  elen_t w0;
  elen_t w1;
  next_word(w0);
  next_word(w1);
  push_command(CONV_NONE, EW64, 10'd2, FU_ALU_SLDU);
  operand_issued_i = 1'b1;
  @(negedge clk_i);
  operand_valid_i = 1'b1;
  operand_i       = w0;
  @(negedge clk_i);
  operand_issued_i = 1'b0;
  operand_i        = w1;
  @(negedge clk_i);
  operand_valid_i = 1'b0;
  repeat (3) @(negedge clk_i);
  if (operand_queue_ready_o !== 1'b0) report_error("queue ready high with all credits used");
  if (operand_o !== w0) report_error($sformatf("operand_o %h, expected %h", operand_o, w0));
  operand_ready_i = 2'b10;
  @(negedge clk_i);
  operand_ready_i = '0;
  if (operand_queue_ready_o !== 1'b1) report_error("queue ready still low after a pop");
  if (operand_o !== w1) report_error($sformatf("operand_o %h, expected %h", operand_o, w1));
  operand_ready_i = 2'b01;
  @(negedge clk_i);
  operand_ready_i = '0;
  beats_checked += 2;
  if (operand_valid_o !== 1'b0) report_error("operand_valid_o high after the last word");
endtask

task automatic back_pressure();
  run_command(CONV_SEXT4, EW8, 10'd16, FU_MFPU_ADDRGEN, 2, 3, 0);
endtask

task automatic flush_mid_command();
  run_command(CONV_SEXT2, EW8, 10'd16, FU_ALU_SLDU, 2, -1, 1);
  @(negedge clk_i);
  flush_i = 1'b1;
  @(negedge clk_i);
  flush_i = 1'b0;
  if (operand_valid_o !== 1'b0) report_error("operand_valid_o high after flush");
  if (operand_queue_ready_o !== 1'b1) report_error("operand_queue_ready_o low after flush");
  run_command(CONV_ZEXT4, EW16, 10'd4, FU_MFPU_ADDRGEN, 1, -1, 0);
endtask

/* testbench/tb_operand_queue.sv */
// Directed testbench of the operand queue; run it as the simulation top with the project file list
`timescale 1ns/1ps
`default_nettype none

`include "opq_consts.svh"

module tb_operand_queue;

  import opq_pkg::*;

  // The tests need a few hundred cycles
  localparam int unsigned TimeoutCycles = 2000;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  flush_i;
  logic                  cmd_valid_i;
  conv_e                 cmd_conv_i;
  eew_e                  cmd_eew_i;
  elem_cnt_t             cmd_elem_count_i;
  target_fu_e            cmd_target_fu_i;
  elen_t                 operand_i;
  logic                  operand_valid_i;
  logic                  operand_issued_i;
  logic [`OPQ_NR_FU-1:0] operand_ready_i;
  logic                  operand_queue_ready_o;
  elen_t                 operand_o;
  target_fu_e            operand_target_fu_o;
  logic                  operand_valid_o;

  int          errors = 0;
  int          beats_checked = 0;
  int unsigned cycle_count = 0;
  logic [15:0] lfsr_q;

  operand_queue operand_queue_i (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .flush_i              (flush_i),
    .cmd_valid_i          (cmd_valid_i),
    .cmd_conv_i           (cmd_conv_i),
    .cmd_eew_i            (cmd_eew_i),
    .cmd_elem_count_i     (cmd_elem_count_i),
    .cmd_target_fu_i      (cmd_target_fu_i),
    .operand_i            (operand_i),
    .operand_valid_i      (operand_valid_i),
    .operand_issued_i     (operand_issued_i),
    .operand_ready_i      (operand_ready_i),
    .operand_queue_ready_o(operand_queue_ready_o),
    .operand_o            (operand_o),
    .operand_target_fu_o  (operand_target_fu_o),
    .operand_valid_o      (operand_valid_o)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin : timeout_guard
    while (cycle_count < TimeoutCycles) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
    $display("Regression failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic report_error(input string msg);
    errors++;
    $display("error @%0t ns: %s", $time, msg);
  endtask

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic next_word(output elen_t w);
    for (int i = 0; i < 64; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      w[i]   = lfsr_q[0];
    end
  endtask

  // Widening factor that is 1 when the word leaves unchanged or would not fit
  function automatic int widen_factor(input conv_e conv, input eew_e eew);
    int f;
    case (conv)
      CONV_SEXT2, CONV_ZEXT2: f = 2;
      CONV_SEXT4, CONV_ZEXT4: f = 4;
      CONV_SEXT8, CONV_ZEXT8: f = 8;
      default:                f = 1;
    endcase
    if ((8 << eew) * f > 64) f = 1;
    return f;
  endfunction

  // Reference beat where element e starts at byte sel + e*W/8 and grows to F*W bits
  function automatic elen_t expected_beat(input elen_t word, input conv_e conv,
                                          input eew_e eew, input int sel);
    int    f;
    int    w;
    elen_t ones;
    elen_t src;
    elen_t res;
    f    = widen_factor(conv, eew);
    w    = 8 << eew;
    ones = '1;
    res  = '0;
    if (f == 1) return word;
    for (int e = 0; e < 64 / (f * w); e++) begin
      src = (word >> (sel * 8 + e * w)) & (ones >> (64 - w));
      if (conv inside {CONV_SEXT2, CONV_SEXT4, CONV_SEXT8} && src[w-1]) begin
        src = src | ~(ones >> (64 - w));
      end
      res = res | ((src & (ones >> (64 - f * w))) << (e * f * w));
    end
    return res;
  endfunction

  `include "tb_operand_queue_tasks.svh"

  initial begin : main
    rst_ni           = 1'b0;
    flush_i          = 1'b0;
    cmd_valid_i      = 1'b0;
    cmd_conv_i       = CONV_NONE;
    cmd_eew_i        = EW8;
    cmd_elem_count_i = '0;
    cmd_target_fu_i  = FU_ALU_SLDU;
    operand_i        = '0;
    operand_valid_i  = 1'b0;
    operand_issued_i = 1'b0;
    operand_ready_i  = '0;
    lfsr_q           = 16'd53;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    reset_values();
    pass_through();
    sign_zero_extension();
    credit_flow();
    back_pressure();
    flush_mid_command();

    repeat (4) @(negedge clk_i);
    $display("Errors: %0d, beats checked: %0d", errors, beats_checked);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+hw
+incdir+testbench
hw/opq_pkg.sv
hw/opq_fifo.sv
hw/opq_credit_counter.sv
hw/opq_widen.sv
hw/opq_sequencer.sv
hw/operand_queue.sv
testbench/tb_operand_queue.sv

/* Bender.yml */
package:
  name: operand_queue

sources:
  - include_dirs:
      - hw
    files:
      - hw/opq_pkg.sv
      - hw/opq_fifo.sv
      - hw/opq_credit_counter.sv
      - hw/opq_widen.sv
      - hw/opq_sequencer.sv
      - hw/operand_queue.sv
  - target: test
    include_dirs:
      - hw
      - testbench
    files:
      - testbench/tb_operand_queue.sv
